/* source/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // sampling ticks per serial bit
  localparam int OVERSAMPLE = 8;
  localparam int OS_CNT_W = $clog2(OVERSAMPLE);

  // oversampled values that take part in the receive vote
  localparam int SAMPLE_DEPTH = 5;
  localparam int VOTE_W = $clog2(SAMPLE_DEPTH + 1);

  // bit timer load on a start edge, lands the next samples mid-bit
  localparam int RX_START_OFFSET = 2;

  // number of data bits minus one
  typedef logic [2:0] data_len_t;
  typedef logic [7:0] uart_byte_t;
  // baud divider reload value
  typedef logic [19:0] clk_div_t;
  typedef logic [2:0] bit_cnt_t;
  typedef logic [OS_CNT_W-1:0] os_cnt_t;
  typedef logic [VOTE_W-1:0] vote_cnt_t;

  typedef enum logic [1:0] {
    parity_none,
    parity_even,
    parity_odd
  } parity_e;

  typedef enum logic {
    stop_one,
    stop_two
  } stop_e;

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_parity,
    tx_stop
  } tx_state_e;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_e;

endpackage

`default_nettype wire

/* source/uart_baud_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_baud_gen (
  input  wire                 Slow_clk,
  input  wire                 rst_n,
  input  wire uart_pkg::clk_div_t clock_divider,
  output logic                sample_tick
);
  import uart_pkg::*;

  clk_div_t counter;

  // one tick per clock_divider+1 cycles on the reload cycle
  assign sample_tick = (counter == '0);

  always_ff @(posedge Slow_clk) begin
    if (!rst_n) begin
      counter <= '0;
    end else if (sample_tick) begin
      counter <= clock_divider;
    end else begin
      counter <= counter - clk_div_t'(1);
    end
  end

endmodule

`default_nettype wire

/* source/uart_rx_sampler.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx_sampler (
  input  wire  Slow_clk,
  input  wire  rst_n,
  input  wire  sample_tick,
  input  wire  rxd,
  output logic rx_bit,
  output logic rx_tick
);
  import uart_pkg::*;

  logic [1:0] sync_q;
  logic [SAMPLE_DEPTH-2:0] samples_q;
  logic [SAMPLE_DEPTH-1:0] window;
  vote_cnt_t ones;

  // live synchronized value plus the older samples
  assign window = {samples_q, sync_q[1]};

  always_comb begin
    ones = '0;
    for (int i = 0; i < SAMPLE_DEPTH; i++) begin
      ones = ones + vote_cnt_t'(window[i]);
    end
  end

  // two-flop synchronizer, line idles high
  always_ff @(posedge Slow_clk) begin
    if (!rst_n) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[0], rxd};
    end
  end

  always_ff @(posedge Slow_clk) begin
    if (!rst_n) begin
      samples_q <= '1;
      rx_bit    <= 1'b1;
      rx_tick   <= 1'b0;
    end else begin
      rx_tick <= sample_tick;
      if (sample_tick) begin
        samples_q <= window[SAMPLE_DEPTH-2:0];
        // majority of five, a short glitch cannot flip it
        rx_bit    <= (ones > vote_cnt_t'(SAMPLE_DEPTH / 2));
      end
    end
  end

endmodule

`default_nettype wire

/* source/uart_rx_framer.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx_framer (
  input  wire                    Slow_clk,
  input  wire                    rst_n,
  input  wire                    rx_bit,
  input  wire                    rx_tick,
  input  wire uart_pkg::data_len_t data_length,
  input  wire uart_pkg::parity_e   parity,
  input  wire uart_pkg::stop_e     stop,
  output logic                   read_valid,
  output uart_pkg::uart_byte_t   read_data
);
  import uart_pkg::*;

  rx_state_e state;
  os_cnt_t   bit_timer;
  bit_cnt_t  bit_cnt;
  bit_cnt_t  stop_last;
  logic      bit_tick;
  logic      parity_acc;

  // timer wraps through zero to give one bit every OVERSAMPLE rx ticks
  assign bit_tick  = rx_tick && (bit_timer == '0);
  assign stop_last = (stop == stop_two) ? bit_cnt_t'(1) : '0;

  always_ff @(posedge Slow_clk) begin
    if (!rst_n) begin
      state      <= rx_idle;
      bit_timer  <= '0;
      bit_cnt    <= '0;
      parity_acc <= 1'b0;
      read_valid <= 1'b0;
    end else begin
      read_valid <= 1'b0;
      if (rx_tick) begin
        bit_timer <= bit_timer - os_cnt_t'(1);
      end
      case (state)
        rx_idle: begin
          // falling edge realigns the timer to mid-bit
          if (rx_tick && !rx_bit) begin
            state     <= rx_start;
            bit_timer <= os_cnt_t'(RX_START_OFFSET);
          end
        end
        rx_start: begin
          if (bit_tick) begin
            // still high at mid-bit means it was a glitch
            state      <= rx_bit ? rx_idle : rx_data;
            bit_cnt    <= '0;
            parity_acc <= (parity == parity_odd);
          end
        end
        rx_data: begin
          if (bit_tick) begin
            read_data[bit_cnt] <= rx_bit;
            parity_acc         <= parity_acc ^ rx_bit;
            bit_cnt            <= bit_cnt + bit_cnt_t'(1);
            if (bit_cnt == data_length) begin
              bit_cnt <= '0;
              if (parity == parity_none) begin
                state      <= rx_stop;
                read_valid <= 1'b1;
              end else begin
                state <= rx_parity;
              end
            end
          end
        end
        rx_parity: begin
          if (bit_tick) begin
            bit_cnt <= '0;
            if (parity_acc == rx_bit) begin
              state      <= rx_stop;
              read_valid <= 1'b1;
            end else begin
              state <= rx_idle;
            end
          end
        end
        rx_stop: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + bit_cnt_t'(1);
            // framing error or last stop bit seen
            if (!rx_bit || bit_cnt == stop_last) begin
              state <= rx_idle;
            end
          end
        end
        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/uart_tx_framer.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_tx_framer (
  input  wire                     Slow_clk,
  input  wire                     rst_n,
  input  wire                     sample_tick,
  input  wire                     write_valid,
  input  wire uart_pkg::uart_byte_t write_data,
  input  wire uart_pkg::data_len_t  data_length,
  input  wire uart_pkg::parity_e    parity,
  input  wire uart_pkg::stop_e      stop,
  output logic                    write_ready,
  output logic                    txd
);
  import uart_pkg::*;

  tx_state_e state;
  os_cnt_t   prescaler;
  bit_cnt_t  bit_cnt;
  bit_cnt_t  stop_last;
  logic      bit_tick;
  logic      last_data;
  logic      parity_acc;
  logic      txd_next;

  // every eighth sample tick of the free-running prescaler ends a bit
  assign bit_tick  = sample_tick && (prescaler == os_cnt_t'(OVERSAMPLE - 1));
  assign last_data = (bit_cnt == data_length);
  assign stop_last = (stop == stop_two) ? bit_cnt_t'(1) : '0;

  // byte is consumed once its last data bit has gone out
  assign write_ready = (state == tx_data) && bit_tick && last_data;

  always_comb begin
    case (state)
      tx_start:  txd_next = 1'b0;
      tx_data:   txd_next = write_data[bit_cnt];
      tx_parity: txd_next = parity_acc;
      default:   txd_next = 1'b1;
    endcase
  end

  always_ff @(posedge Slow_clk) begin
    if (!rst_n) begin
      prescaler <= '0;
    end else if (sample_tick) begin
      prescaler <= prescaler + os_cnt_t'(1);
    end
  end

  always_ff @(posedge Slow_clk) begin
    if (!rst_n) begin
      state      <= tx_idle;
      bit_cnt    <= '0;
      parity_acc <= 1'b0;
      txd        <= 1'b1;
    end else begin
      txd <= txd_next;
      case (state)
        tx_idle: begin
          if (write_valid && bit_tick) begin
            state <= tx_start;
          end
        end
        tx_start: begin
          if (bit_tick) begin
            state      <= tx_data;
            bit_cnt    <= '0;
            // odd parity seeds the running xor with one
            parity_acc <= (parity == parity_odd);
          end
        end
        tx_data: begin
          if (bit_tick) begin
            parity_acc <= parity_acc ^ txd_next;
            bit_cnt    <= bit_cnt + bit_cnt_t'(1);
            if (last_data) begin
              bit_cnt <= '0;
              state   <= (parity == parity_none) ? tx_stop : tx_parity;
            end
          end
        end
        tx_parity: begin
          if (bit_tick) begin
            state   <= tx_stop;
            bit_cnt <= '0;
          end
        end
        tx_stop: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + bit_cnt_t'(1);
            // next frame follows with no idle bit in between
            if (bit_cnt == stop_last) begin
              state <= write_valid ? tx_start : tx_idle;
            end
          end
        end
        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/uart_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_ctrl (
  input  wire                     Slow_clk,
  input  wire                     rst_n,
  input  wire uart_pkg::data_len_t  data_length,
  input  wire uart_pkg::parity_e    parity,
  input  wire uart_pkg::stop_e      stop,
  input  wire uart_pkg::clk_div_t   clock_divider,
  input  wire                     write_valid,
  input  wire uart_pkg::uart_byte_t write_data,
  input  wire                     rxd,
  output logic                    write_ready,
  output logic                    read_valid,
  output uart_pkg::uart_byte_t    read_data,
  output logic                    txd
);
  import uart_pkg::*;

  logic sample_tick;
  logic rx_bit;
  logic rx_tick;

  // one tick source paces both directions
  uart_baud_gen u_baud_gen (
    .Slow_clk      (Slow_clk),
    .rst_n         (rst_n),
    .clock_divider (clock_divider),
    .sample_tick   (sample_tick)
  );

  uart_rx_sampler u_rx_sampler (
    .Slow_clk    (Slow_clk),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .rxd         (rxd),
    .rx_bit      (rx_bit),
    .rx_tick     (rx_tick)
  );

  uart_rx_framer u_rx_framer (
    .Slow_clk    (Slow_clk),
    .rst_n       (rst_n),
    .rx_bit      (rx_bit),
    .rx_tick     (rx_tick),
    .data_length (data_length),
    .parity      (parity),
    .stop        (stop),
    .read_valid  (read_valid),
    .read_data   (read_data)
  );

  uart_tx_framer u_tx_framer (
    .Slow_clk    (Slow_clk),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .write_valid (write_valid),
    .write_data  (write_data),
    .data_length (data_length),
    .parity      (parity),
    .stop        (stop),
    .write_ready (write_ready),
    .txd         (txd)
  );

endmodule

`default_nettype wire

/* testbench/uart_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_ctrl_tb;
  import uart_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DIV = 3;
  localparam int BIT_CYCLES = OVERSAMPLE * (DIV + 1);
  localparam int NUM_FRAMES = 80;
  // longest frame is 12 bits plus half again for gaps and start latency
  localparam int WATCHDOG_NS = NUM_FRAMES * 12 * BIT_CYCLES * CLK_PERIOD * 3 / 2;

  logic       Slow_clk;
  logic       rst_n;
  data_len_t  data_length;
  parity_e    parity;
  stop_e      stop;
  clk_div_t   clock_divider;
  logic       write_valid;
  uart_byte_t write_data;
  logic       write_ready;
  logic       read_valid;
  uart_byte_t read_data;
  logic       txd;
  logic       loopback;
  logic       bb_rxd;
  logic [31:0] lfsr_state = 32'hd678f67c;
  int         checks = 0;
  int         errors = 0;
  uart_byte_t expected_q[$];

  // rxd comes from txd or from the bit-banged driver
  wire rxd = loopback ? txd : bb_rxd;

  uart_ctrl uut (
    .Slow_clk      (Slow_clk),
    .rst_n         (rst_n),
    .data_length   (data_length),
    .parity        (parity),
    .stop          (stop),
    .clock_divider (clock_divider),
    .write_valid   (write_valid),
    .write_data    (write_data),
    .rxd           (rxd),
    .write_ready   (write_ready),
    .read_valid    (read_valid),
    .read_data     (read_data),
    .txd           (txd)
  );

  initial begin
    Slow_clk = 1'b0;
    forever #(CLK_PERIOD / 2) Slow_clk = ~Slow_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic uart_byte_t data_mask(input data_len_t len);
    logic [8:0] m;
    m = (9'd1 << (int'(len) + 1)) - 9'd1;
    return m[7:0];
  endfunction

  // payload bits that the receiver delivers
  function automatic uart_byte_t expected_byte(input uart_byte_t b, input data_len_t len);
    return b & data_mask(len);
  endfunction

  // line levels in send order with stop and idle levels at 1
  function automatic logic [11:0] ref_frame(input uart_byte_t b, input data_len_t len,
                                            input parity_e p);
    logic [11:0] frame;
    logic par;
    frame = '1;
    frame[0] = 1'b0;
    par = (p == parity_odd);
    for (int i = 0; i <= int'(len); i++) begin
      frame[i + 1] = b[i];
      par = par ^ b[i];
    end
    if (p != parity_none) begin
      frame[int'(len) + 2] = par;
    end
    return frame;
  endfunction

  function automatic int frame_len(input data_len_t len, input parity_e p, input stop_e s);
    return 2 + int'(len) + ((p != parity_none) ? 1 : 0) + ((s == stop_two) ? 2 : 1);
  endfunction

  // every received byte is matched against the oldest outstanding one
  always @(negedge Slow_clk) begin
    uart_byte_t got;
    uart_byte_t want;
    if (rst_n && read_valid) begin
      checks++;
      got = read_data & data_mask(data_length);
      if (expected_q.size() == 0) begin
        $display("read_valid raised at %0t with no byte outstanding", $time);
        errors++;
      end else begin
        want = expected_q.pop_front();
        if (got != want) begin
          $display("[ERROR] %0t: read_data %h, expected %h", $time, got, want);
          errors++;
        end
      end
    end
  end

  task automatic check_idle_outputs();
    checks++;
    if (txd !== 1'b1 || write_ready !== 1'b0 || read_valid !== 1'b0) begin
      $display("[ERROR] %0t: not idle, txd %b write_ready %b read_valid %b",
               $time, txd, write_ready, read_valid);
      errors++;
    end
  endtask

  task automatic write_byte(input uart_byte_t b);
    @(negedge Slow_clk);
    write_valid = 1'b1;
    write_data = b;
    expected_q.push_back(expected_byte(b, data_length));
    @(negedge Slow_clk);
    // transfer happens on the posedge after write_ready is seen
    while (!write_ready) @(negedge Slow_clk);
  endtask

  task automatic release_write();
    @(negedge Slow_clk);
    write_valid = 1'b0;
  endtask

  task automatic check_frame_shape(input logic [11:0] frame, input int nbits);
    while (txd !== 1'b0) @(negedge Slow_clk);
    repeat (BIT_CYCLES / 2 - 1) @(negedge Slow_clk);
    for (int k = 0; k < nbits; k++) begin
      checks++;
      if (txd !== frame[k]) begin
        $display("[ERROR] %0t: txd bit %0d is %b, expected %b", $time, k, txd, frame[k]);
        errors++;
      end
      if (k < nbits - 1) begin
        repeat (BIT_CYCLES) @(negedge Slow_clk);
      end
    end
  endtask

  task automatic loopback_byte(input uart_byte_t b);
    logic [11:0] frame;
    int nbits;
    frame = ref_frame(b, data_length, parity);
    nbits = frame_len(data_length, parity, stop);
    fork
      begin
        write_byte(b);
        release_write();
      end
      check_frame_shape(frame, nbits);
    join
  endtask

  task automatic drive_serial(input logic [11:0] frame, input int nbits);
    for (int i = 0; i < nbits; i++) begin
      bb_rxd = frame[i];
      repeat (BIT_CYCLES) @(negedge Slow_clk);
    end
    bb_rxd = 1'b1;
  endtask

  // one tick of low is too short for three low samples in the vote
  task automatic drive_short_start();
    bb_rxd = 1'b0;
    repeat (DIV + 1) @(negedge Slow_clk);
    bb_rxd = 1'b1;
    repeat (12 * BIT_CYCLES) @(negedge Slow_clk);
  endtask

  // let both framers finish the stop bits before the config changes
  task automatic settle();
    while (expected_q.size() != 0) @(negedge Slow_clk);
    repeat (3 * BIT_CYCLES) @(negedge Slow_clk);
  endtask

  initial begin
    int len;
    int par;
    int stp;
    logic [11:0] frame;
    uart_byte_t b;
    rst_n = 1'b0;
    data_length = data_len_t'(7);
    parity = parity_none;
    stop = stop_one;
    clock_divider = clk_div_t'(DIV);
    write_valid = 1'b0;
    write_data = '0;
    loopback = 1'b0;
    bb_rxd = 1'b1;

    repeat (4) begin
      @(negedge Slow_clk);
      check_idle_outputs();
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge Slow_clk);
      check_idle_outputs();
    end
    loopback = 1'b1;

    // 8N1 loopback
    repeat (16) loopback_byte(uart_byte_t'(rand_bits(8)));
    settle();

    for (len = 4; len < 8; len++) begin
      for (par = 0; par < 3; par++) begin
        for (stp = 0; stp < 2; stp++) begin
          data_length = data_len_t'(len);
          parity = parity_e'(par);
          stop = stop_e'(stp);
          repeat (2) loopback_byte(uart_byte_t'(rand_bits(8)));
          settle();
        end
      end
    end

    // write_valid stays high across the whole burst
    data_length = data_len_t'(4 + int'(rand_bits(2)));
    parity = parity_odd;
    stop = stop_e'(rand_bits(1));
    repeat (8) write_byte(uart_byte_t'(rand_bits(8)));
    release_write();
    settle();

    loopback = 1'b0;
    data_length = data_len_t'(7);
    parity = parity_even;
    stop = stop_one;
    frame = ref_frame(uart_byte_t'(rand_bits(8)), data_length, parity);
    // parity bit follows the eight data bits
    frame[9] = ~frame[9];
    drive_serial(frame, frame_len(data_length, parity, stop));
    // wait out any false start on a flipped parity bit of 0
    repeat (12 * BIT_CYCLES) @(negedge Slow_clk);
    drive_short_start();
    b = uart_byte_t'(rand_bits(8));
    expected_q.push_back(expected_byte(b, data_length));
    drive_serial(ref_frame(b, data_length, parity), frame_len(data_length, parity, stop));
    settle();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uart_ctrl.f */
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_rx_sampler.sv
source/uart_rx_framer.sv
source/uart_tx_framer.sv
source/uart_ctrl.sv
testbench/uart_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= uart_ctrl_tb
FILELIST  ?= uart_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= RESULT: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
